//--- source/mem_if_pkg.sv
package mem_if_pkg;

    // address and data width of every port
    localparam int xlen = 32;

    // error class returned with a response
    typedef enum logic [1:0] {
        fault_none   = 2'b00,
        fault_access = 2'b01,
        fault_page   = 2'b10
    } fault_type;

    // privilege level of the requester, encoded as in mstatus.mpp
    typedef enum logic [1:0] {
        user_mode       = 2'b00,
        supervisor_mode = 2'b01,
        machine_mode    = 2'b11
    } priv_mode;

endpackage

//--- source/sv32_pkg.sv
package sv32_pkg;

    // pte flag bit positions
    localparam int pte_v = 0;
    localparam int pte_r = 1;
    localparam int pte_w = 2;
    localparam int pte_x = 3;
    localparam int pte_u = 4;
    localparam int pte_g = 5;
    localparam int pte_a = 6;
    localparam int pte_d = 7;

    // virtual address is vpn1 | vpn0 | offset
    localparam int vpn_width    = 10;
    localparam int offset_width = 12;

    // ppn1 is the upper ppn field, ppn0 has the width of a vpn
    localparam int ppn1_width = 12;

    // pte is four bytes
    localparam int pte_shift = 2;

endpackage

//--- source/pte_checker.sv
module pte_checker
    import mem_if_pkg::*, sv32_pkg::*;
#(
    parameter bit execute_mode = 1'b0
) (
    input  logic [xlen-1:0]                 pte,
    input  logic                            level,
    input  logic                            is_store,
    input  priv_mode                        mode,
    input  logic                            mxr,
    input  logic                            sum,
    input  logic                            mem_error,
    output logic                            is_leaf,
    output logic                            fault,
    output fault_type                       errty,
    output logic [ppn1_width+vpn_width-1:0] next_ppn
);

    logic                 v;
    logic                 r;
    logic                 w;
    logic                 x;
    logic                 u;
    logic                 g;
    logic                 a;
    logic                 d;
    logic [vpn_width-1:0] ppn0;
    logic                 bad_encoding;
    logic                 bad_pointer;
    logic                 bad_priv;
    logic                 bad_access;
    logic                 misaligned;
    logic                 page_fault;

    assign v = pte[pte_v];
    assign r = pte[pte_r];
    assign w = pte[pte_w];
    assign x = pte[pte_x];
    assign u = pte[pte_u];
    assign g = pte[pte_g];
    assign a = pte[pte_a];
    assign d = pte[pte_d];

    assign next_ppn = pte[xlen-1 -: ppn1_width+vpn_width];
    assign ppn0     = pte[xlen-ppn1_width-1 -: vpn_width];

    // x=w=r=0 is a pointer to the next table
    assign is_leaf = r | w | x;

    // invalid, reserved w-only encoding, or global mapping (not supported)
    assign bad_encoding = !v | (w & !r) | g;

    // a/d/u are reserved on pointers, and level 0 must end in a leaf
    assign bad_pointer = !is_leaf & (a | d | u | !level);

    // s-mode never executes user pages, and reads them only with sum
    assign bad_priv = is_leaf & ((mode == supervisor_mode & u & (execute_mode | !sum))
                               | (mode == user_mode & !u));

    always_comb begin
        if (!is_leaf) begin
            bad_access = 1'b0;
        end else if (execute_mode) begin
            bad_access = !x;
        end else if (is_store) begin
            bad_access = !w;
        end else begin
            // mxr makes execute-only pages readable
            bad_access = !r & !(mxr & x);
        end
    end

    // superpage must be aligned to 4 MiB
    assign misaligned = is_leaf & level & (ppn0 != '0);

    assign page_fault = bad_encoding | bad_pointer | bad_priv | bad_access | misaligned;
    assign fault      = mem_error | page_fault;

    always_comb begin
        if (mem_error) begin
            errty = fault_access;
        end else if (page_fault) begin
            errty = fault_page;
        end else begin
            errty = fault_none;
        end
    end

endmodule

//--- source/page_table_walker.sv
module page_table_walker
    import mem_if_pkg::*, sv32_pkg::*;
#(
    parameter bit execute_mode = 1'b0
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              req_valid,
    output logic              req_ready,
    input  logic [xlen-1:0]   req_addr,
    input  logic              req_wen,
    input  logic [xlen-1:0]   req_wdata,
    input  logic [xlen/8-1:0] req_wmask,
    output logic              resp_valid,
    output logic [xlen-1:0]   resp_rdata,
    output logic              resp_error,
    output fault_type         resp_errty,

    input  priv_mode          mode,
    input  logic [xlen-1:0]   satp,
    input  logic              mxr,
    input  logic              sum,

    output logic              pte_valid,
    input  logic              pte_ready,
    output logic [xlen-1:0]   pte_addr,
    output logic              pte_wen,
    output logic [xlen-1:0]   pte_wdata,
    output logic [xlen/8-1:0] pte_wmask,
    input  logic              pte_resp_valid,
    input  logic [xlen-1:0]   pte_rdata,
    input  logic              pte_error,

    output logic              dat_valid,
    input  logic              dat_ready,
    output logic [xlen-1:0]   dat_addr,
    output logic              dat_wen,
    output logic [xlen-1:0]   dat_wdata,
    output logic [xlen/8-1:0] dat_wmask,
    input  logic              dat_resp_valid,
    input  logic [xlen-1:0]   dat_rdata,
    input  logic              dat_error
);

    // ppn bits that fit in a 32-bit physical address
    localparam int pa_ppn_width = xlen - offset_width;

    typedef enum logic [2:0] {
        idle,
        walk_req,
        walk_wait,
        data_req,
        data_wait,
        respond,
        ad_req,
        ad_wait
    } walk_state;

    walk_state                        state;
    logic                             sv32_enable;
    logic                             level;
    logic [xlen-1:0]                  pte_addr_q;
    logic [xlen-1:0]                  phys_addr;
    logic [xlen-1:0]                  saved_pte;
    logic [xlen-1:0]                  ad_pte;
    logic                             need_ad;

    // latched request
    logic [xlen-1:0]                  s_addr;
    logic                             s_wen;
    logic [xlen-1:0]                  s_wdata;
    logic [xlen/8-1:0]                s_wmask;
    logic [vpn_width-1:0]             s_vpn0;
    logic [offset_width-1:0]          s_offset;

    logic [xlen-1:0]                  result_rdata;
    logic                             result_error;
    fault_type                        result_errty;

    logic                             chk_leaf;
    logic                             chk_fault;
    fault_type                        chk_errty;
    logic [ppn1_width+vpn_width-1:0]  chk_ppn;

    // machine mode and satp.mode=0 both bypass translation
    assign sv32_enable = (mode != machine_mode) && satp[xlen-1];

    assign s_vpn0   = s_addr[offset_width +: vpn_width];
    assign s_offset = s_addr[offset_width-1:0];

    pte_checker #(
        .execute_mode(execute_mode)
    ) pte_checker_i (
        .pte      (pte_rdata),
        .level    (level),
        .is_store (s_wen),
        .mode     (mode),
        .mxr      (mxr),
        .sum      (sum),
        .mem_error(pte_error),
        .is_leaf  (chk_leaf),
        .fault    (chk_fault),
        .errty    (chk_errty),
        .next_ppn (chk_ppn)
    );

    // writeback only when a or d would change
    assign need_ad = !saved_pte[pte_a] || (s_wen && !saved_pte[pte_d]);

    always_comb begin
        ad_pte        = saved_pte;
        ad_pte[pte_a] = 1'b1;
        if (s_wen) begin
            ad_pte[pte_d] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (sv32_enable && req_valid) begin
                        state      <= walk_req;
                        s_addr     <= req_addr;
                        s_wen      <= req_wen;
                        s_wdata    <= req_wdata;
                        s_wmask    <= req_wmask;
                        level      <= 1'b1;
                        // root table entry from satp.ppn and vpn1
                        pte_addr_q <= {satp[pa_ppn_width-1:0], req_addr[xlen-1 -: vpn_width],
                                       {pte_shift{1'b0}}};
                    end
                end
                walk_req: begin
                    if (pte_ready) begin
                        state <= walk_wait;
                    end
                end
                walk_wait: begin
                    if (pte_resp_valid) begin
                        if (chk_fault) begin
                            state        <= respond;
                            result_rdata <= '0;
                            result_error <= 1'b1;
                            result_errty <= chk_errty;
                        end else if (chk_leaf) begin
                            state     <= data_req;
                            saved_pte <= pte_rdata;
                            // superpage keeps vpn0 from the virtual address
                            if (level) begin
                                phys_addr <= {chk_ppn[pa_ppn_width-1:vpn_width], s_vpn0,
                                              s_offset};
                            end else begin
                                phys_addr <= {chk_ppn[pa_ppn_width-1:0], s_offset};
                            end
                        end else begin
                            state      <= walk_req;
                            level      <= 1'b0;
                            pte_addr_q <= {chk_ppn[pa_ppn_width-1:0], s_vpn0,
                                           {pte_shift{1'b0}}};
                        end
                    end
                end
                data_req: begin
                    if (dat_ready) begin
                        state <= data_wait;
                    end
                end
                data_wait: begin
                    if (dat_resp_valid) begin
                        state        <= respond;
                        result_rdata <= dat_rdata;
                        result_error <= dat_error;
                        result_errty <= dat_error ? fault_access : fault_none;
                    end
                end
                respond: begin
                    // pte_addr_q still points at the leaf
                    state <= (result_error || !need_ad) ? idle : ad_req;
                end
                ad_req: begin
                    if (pte_ready) begin
                        state <= ad_wait;
                    end
                end
                ad_wait: begin
                    if (pte_resp_valid) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // requester side, bare mode is a straight connection to dat_
    assign req_ready  = sv32_enable ? (state == idle) : dat_ready;
    assign resp_valid = sv32_enable ? (state == respond) : dat_resp_valid;
    assign resp_rdata = sv32_enable ? result_rdata : dat_rdata;
    assign resp_error = sv32_enable ? result_error : dat_error;
    assign resp_errty = sv32_enable ? result_errty : (dat_error ? fault_access : fault_none);

    assign dat_valid = sv32_enable ? (state == data_req) : req_valid;
    assign dat_addr  = sv32_enable ? phys_addr : req_addr;
    assign dat_wen   = sv32_enable ? s_wen : req_wen;
    assign dat_wdata = sv32_enable ? s_wdata : req_wdata;
    assign dat_wmask = sv32_enable ? s_wmask : req_wmask;

    // pte reads during the walk, one full-word write for a/d
    assign pte_valid = (state == walk_req) || (state == ad_req);
    assign pte_addr  = pte_addr_q;
    assign pte_wen   = (state == ad_req);
    assign pte_wdata = ad_pte;
    assign pte_wmask = {(xlen/8){1'b1}};

    // requester holds its request until it is taken
    assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req_addr));

endmodule

//--- source/mem_arbiter.sv
module mem_arbiter
    import mem_if_pkg::*;
#(
    parameter bit data_priority = 1'b0
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              pte_valid,
    output logic              pte_ready,
    input  logic [xlen-1:0]   pte_addr,
    input  logic              pte_wen,
    input  logic [xlen-1:0]   pte_wdata,
    input  logic [xlen/8-1:0] pte_wmask,
    output logic              pte_resp_valid,
    output logic [xlen-1:0]   pte_rdata,
    output logic              pte_error,

    input  logic              dat_valid,
    output logic              dat_ready,
    input  logic [xlen-1:0]   dat_addr,
    input  logic              dat_wen,
    input  logic [xlen-1:0]   dat_wdata,
    input  logic [xlen/8-1:0] dat_wmask,
    output logic              dat_resp_valid,
    output logic [xlen-1:0]   dat_rdata,
    output logic              dat_error,

    output logic              mem_valid,
    input  logic              mem_ready,
    output logic [xlen-1:0]   mem_addr,
    output logic              mem_wen,
    output logic [xlen-1:0]   mem_wdata,
    output logic [xlen/8-1:0] mem_wmask,
    input  logic              mem_resp_valid,
    input  logic [xlen-1:0]   mem_rdata,
    input  logic              mem_error
);

    logic busy;
    logic owner_dat;
    logic sel_dat;

    // data wins when the pte port is quiet, or on a tie with data_priority
    assign sel_dat = pte_valid ? (dat_valid && data_priority) : 1'b1;

    // no new request while a transaction is outstanding
    assign mem_valid = !busy && (pte_valid || dat_valid);
    assign mem_addr  = sel_dat ? dat_addr : pte_addr;
    assign mem_wen   = sel_dat ? dat_wen : pte_wen;
    assign mem_wdata = sel_dat ? dat_wdata : pte_wdata;
    assign mem_wmask = sel_dat ? dat_wmask : pte_wmask;

    assign pte_ready = !busy && !sel_dat && mem_ready;
    assign dat_ready = !busy && sel_dat && mem_ready;

    // response goes back to the port that owns the transaction
    assign pte_resp_valid = mem_resp_valid && busy && !owner_dat;
    assign dat_resp_valid = mem_resp_valid && busy && owner_dat;
    assign pte_rdata      = mem_rdata;
    assign dat_rdata      = mem_rdata;
    assign pte_error      = mem_error;
    assign dat_error      = mem_error;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_dat <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            busy      <= 1'b1;
            owner_dat <= sel_dat;
        end else if (mem_resp_valid) begin
            busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset) mem_resp_valid |-> busy);

    // a data request that loses stays up with the same address
    assert property (@(posedge clk) disable iff (reset)
        dat_valid && !dat_ready |=> dat_valid && $stable(dat_addr));

endmodule

//--- source/mmu_top.sv
module mmu_top
    import mem_if_pkg::*;
#(
    parameter bit execute_mode  = 1'b0,
    parameter bit data_priority = 1'b0
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              req_valid,
    output logic              req_ready,
    input  logic [xlen-1:0]   req_addr,
    input  logic              req_wen,
    input  logic [xlen-1:0]   req_wdata,
    input  logic [xlen/8-1:0] req_wmask,
    output logic              resp_valid,
    output logic [xlen-1:0]   resp_rdata,
    output logic              resp_error,
    output fault_type         resp_errty,

    input  priv_mode          mode,
    input  logic [xlen-1:0]   satp,
    input  logic              mxr,
    input  logic              sum,

    output logic              mem_valid,
    input  logic              mem_ready,
    output logic [xlen-1:0]   mem_addr,
    output logic              mem_wen,
    output logic [xlen-1:0]   mem_wdata,
    output logic [xlen/8-1:0] mem_wmask,
    input  logic              mem_resp_valid,
    input  logic [xlen-1:0]   mem_rdata,
    input  logic              mem_error
);

    // walker to arbiter, pte side
    logic              pte_valid;
    logic              pte_ready;
    logic [xlen-1:0]   pte_addr;
    logic              pte_wen;
    logic [xlen-1:0]   pte_wdata;
    logic [xlen/8-1:0] pte_wmask;
    logic              pte_resp_valid;
    logic [xlen-1:0]   pte_rdata;
    logic              pte_error;

    // walker to arbiter, data side
    logic              dat_valid;
    logic              dat_ready;
    logic [xlen-1:0]   dat_addr;
    logic              dat_wen;
    logic [xlen-1:0]   dat_wdata;
    logic [xlen/8-1:0] dat_wmask;
    logic              dat_resp_valid;
    logic [xlen-1:0]   dat_rdata;
    logic              dat_error;

    page_table_walker #(
        .execute_mode(execute_mode)
    ) page_table_walker_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .req_wen       (req_wen),
        .req_wdata     (req_wdata),
        .req_wmask     (req_wmask),
        .resp_valid    (resp_valid),
        .resp_rdata    (resp_rdata),
        .resp_error    (resp_error),
        .resp_errty    (resp_errty),
        .mode          (mode),
        .satp          (satp),
        .mxr           (mxr),
        .sum           (sum),
        .pte_valid     (pte_valid),
        .pte_ready     (pte_ready),
        .pte_addr      (pte_addr),
        .pte_wen       (pte_wen),
        .pte_wdata     (pte_wdata),
        .pte_wmask     (pte_wmask),
        .pte_resp_valid(pte_resp_valid),
        .pte_rdata     (pte_rdata),
        .pte_error     (pte_error),
        .dat_valid     (dat_valid),
        .dat_ready     (dat_ready),
        .dat_addr      (dat_addr),
        .dat_wen       (dat_wen),
        .dat_wdata     (dat_wdata),
        .dat_wmask     (dat_wmask),
        .dat_resp_valid(dat_resp_valid),
        .dat_rdata     (dat_rdata),
        .dat_error     (dat_error)
    );

    mem_arbiter #(
        .data_priority(data_priority)
    ) mem_arbiter_i (
        .clk           (clk),
        .reset         (reset),
        .pte_valid     (pte_valid),
        .pte_ready     (pte_ready),
        .pte_addr      (pte_addr),
        .pte_wen       (pte_wen),
        .pte_wdata     (pte_wdata),
        .pte_wmask     (pte_wmask),
        .pte_resp_valid(pte_resp_valid),
        .pte_rdata     (pte_rdata),
        .pte_error     (pte_error),
        .dat_valid     (dat_valid),
        .dat_ready     (dat_ready),
        .dat_addr      (dat_addr),
        .dat_wen       (dat_wen),
        .dat_wdata     (dat_wdata),
        .dat_wmask     (dat_wmask),
        .dat_resp_valid(dat_resp_valid),
        .dat_rdata     (dat_rdata),
        .dat_error     (dat_error),
        .mem_valid     (mem_valid),
        .mem_ready     (mem_ready),
        .mem_addr      (mem_addr),
        .mem_wen       (mem_wen),
        .mem_wdata     (mem_wdata),
        .mem_wmask     (mem_wmask),
        .mem_resp_valid(mem_resp_valid),
        .mem_rdata     (mem_rdata),
        .mem_error     (mem_error)
    );

endmodule

//--- tb/tb_memory.sv
module tb_memory #(
    parameter int words = 16384
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_valid,
    output logic        mem_ready,
    input  logic [31:0] mem_addr,
    input  logic        mem_wen,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wmask,
    output logic        mem_resp_valid,
    output logic [31:0] mem_rdata,
    output logic        mem_error
);

    logic [31:0] mem [0:words-1];
    integer      seed;
    logic        busy;
    logic [1:0]  count;
    logic [31:0] addr_q;
    logic        wen_q;
    logic [31:0] wdata_q;
    logic [3:0]  wmask_q;

    // fill word is derived from the full byte address
    initial begin
        seed = 32'hab9f;
        for (int i = 0; i < words; i++) begin
            mem[i] = (32'(i) << 2) ^ 32'h5a5a_a5a5;
        end
    end

    function automatic logic in_range(input logic [31:0] addr);
        return addr < 32'(words * 4);
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[15:2]] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem[addr[15:2]];
    endfunction

    // one transaction at a time
    assign mem_ready = !busy;

    always @(posedge clk) begin
        if (reset) begin
            busy           <= 1'b0;
            count          <= 2'd0;
            mem_resp_valid <= 1'b0;
            mem_rdata      <= 32'd0;
            mem_error      <= 1'b0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (!busy && mem_valid) begin
                busy    <= 1'b1;
                // 1 to 3 cycles until the response
                count   <= 2'(1 + ($unsigned($random(seed)) % 3));
                addr_q  <= mem_addr;
                wen_q   <= mem_wen;
                wdata_q <= mem_wdata;
                wmask_q <= mem_wmask;
            end else if (busy) begin
                if (count == 2'd1) begin
                    busy           <= 1'b0;
                    mem_resp_valid <= 1'b1;
                    if (!in_range(addr_q)) begin
                        mem_error <= 1'b1;
                        mem_rdata <= 32'd0;
                    end else begin
                        mem_error <= 1'b0;
                        mem_rdata <= mem[addr_q[15:2]];
                        if (wen_q) begin
                            for (int b = 0; b < 4; b++) begin
                                if (wmask_q[b]) begin
                                    mem[addr_q[15:2]][8*b +: 8] <= wdata_q[8*b +: 8];
                                end
                            end
                        end
                    end
                end else begin
                    count <= count - 2'd1;
                end
            end
        end
    end

endmodule

//--- tb/mmu_tb.sv
module mmu_tb
    import mem_if_pkg::*;
;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    logic [31:0] req_addr;
    logic        req_wen;
    logic [31:0] req_wdata;
    logic [3:0]  req_wmask;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        resp_error;
    fault_type   resp_errty;
    priv_mode    mode;
    logic [31:0] satp;
    logic        mxr;
    logic        sum;

    logic        mem_valid;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic        mem_wen;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wmask;
    logic        mem_resp_valid;
    logic [31:0] mem_rdata;
    logic        mem_error;

    int          tests;
    int          passed;
    int          errors;
    logic        timed_out;

    always #20 clk = ~clk;

    mmu_top #(
        .execute_mode (1'b0),
        .data_priority(1'b0)
    ) mmu_top_i (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_wen(req_wen), .req_wdata(req_wdata), .req_wmask(req_wmask),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .resp_error(resp_error), .resp_errty(resp_errty),
        .mode(mode), .satp(satp), .mxr(mxr), .sum(sum),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_resp_valid(mem_resp_valid), .mem_rdata(mem_rdata), .mem_error(mem_error)
    );

    tb_memory #(
        .words(16384)
    ) tb_memory_i (
        .clk(clk), .reset(reset),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_resp_valid(mem_resp_valid), .mem_rdata(mem_rdata), .mem_error(mem_error)
    );

    task automatic report_timeout(input string what);
        $display("timeout: no %s within 200 cycles in test %0d", what, tests);
        timed_out = 1'b1;
        errors++;
    endtask

    // one request through the DUT, then compare response and memory
    task automatic run_test(input logic [31:0] f[12]);
        int          cycles;
        int          errors_before;
        logic        got;
        logic        err_q;
        logic [1:0]  errty_q;
        logic [31:0] rdata_q;
        logic [31:0] word;

        errors_before = errors;
        tests++;
        @(posedge clk);
        mode      <= priv_mode'(f[0][1:0]);
        satp      <= f[1];
        mxr       <= f[2][0];
        sum       <= f[3][0];
        req_wen   <= f[4][0];
        req_addr  <= f[5];
        req_wdata <= f[6];
        req_wmask <= 4'hf;
        req_valid <= 1'b1;

        // ready is sampled mid-cycle, transfer is on the next edge
        cycles = 0;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (req_ready) begin
                got = 1'b1;
            end else begin
                cycles++;
                if (cycles > 200) begin
                    report_timeout("request acceptance");
                    return;
                end
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;

        cycles = 0;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (resp_valid) begin
                got = 1'b1;
                err_q   = resp_error;
                errty_q = resp_errty;
                rdata_q = resp_rdata;
            end else begin
                cycles++;
                if (cycles > 200) begin
                    report_timeout("response");
                    return;
                end
            end
        end

        // a/d writeback holds ready low until it completes
        cycles = 0;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (req_ready) begin
                got = 1'b1;
            end else begin
                cycles++;
                if (cycles > 200) begin
                    report_timeout("return to idle");
                    return;
                end
            end
        end

        assert (err_q == f[7][0]) else begin
            $display("ERR %0t: test %0d resp_error %0b, expected %0b",
                     $time, tests, err_q, f[7][0]);
            errors++;
        end
        assert (errty_q == f[8][1:0]) else begin
            $display("ERR %0t: test %0d resp_errty %0d, expected %0d",
                     $time, tests, errty_q, f[8][1:0]);
            errors++;
        end
        if (!f[4][0] && !f[7][0]) begin
            assert (rdata_q == f[9]) else begin
                $display("ERR %0t: test %0d rdata %h, expected %h",
                         $time, tests, rdata_q, f[9]);
                errors++;
            end
        end
        if (f[10] != 32'hffff_ffff) begin
            word = tb_memory_i.read_word(f[10]);
            assert (word == f[11]) else begin
                $display("ERR %0t: test %0d word at %h is %h, expected %h",
                         $time, tests, f[10], word, f[11]);
                errors++;
            end
        end

        if (errors == errors_before) begin
            passed++;
            $display("test %0d va %h: ok", tests, f[5]);
        end else begin
            $display("test %0d va %h: failed", tests, f[5]);
        end
    endtask

    initial begin
        int          fd;
        int          count;
        byte         tag;
        string       line;
        logic [31:0] f[12];

        clk       = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_addr  = 32'd0;
        req_wen   = 1'b0;
        req_wdata = 32'd0;
        req_wmask = 4'h0;
        mode      = machine_mode;
        satp      = 32'd0;
        mxr       = 1'b0;
        sum       = 1'b0;
        tests     = 0;
        passed    = 0;
        errors    = 0;
        timed_out = 1'b0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/mmu_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/mmu_patterns.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() < 2) begin
                    continue;
                end
                tag = line.getc(0);
                line = line.substr(1, line.len() - 1);
                if (tag == "M") begin
                    count = $sscanf(line, "%h %h", f[0], f[1]);
                    if (count == 2) begin
                        tb_memory_i.write_word(f[0], f[1]);
                    end
                end else if (tag == "T") begin
                    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5],
                                    f[6], f[7], f[8], f[9], f[10], f[11]);
                    if (count == 12) begin
                        run_test(f);
                    end else begin
                        $display("malformed test record in pattern file");
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, errors);
        if (errors == 0 && tests > 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
source/mem_if_pkg.sv
source/sv32_pkg.sv
source/pte_checker.sv
source/page_table_walker.sv
source/mem_arbiter.sv
source/mmu_top.sv
tb/tb_memory.sv
tb/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the MMU testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module mmu_tb -o mmu_sim

./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

//--- tb/mmu_patterns.txt
# M byte_addr word : preload memory
# T mode satp mxr sum wen vaddr wdata err errty rdata chk_addr chk_word (chk_addr ffffffff = none)
M 00001000 00000801
M 00001004 00000007
M 00001008 000004c7
M 0000100c 00000841
M 00001010 00000c01
M 00001014 04000001
M 00001018 00000000
M 00003000 00000801
M 00002000 000010c7
M 00002004 00001407
M 00002008 00001803
M 0000200c 00001c05
M 00002010 00001ce7
M 00002014 000020d7
M 00002018 000024c9
M 0000201c 000028c7
M 00004010 11111111
M 00005020 22222222
M 00006030 33333333
M 00008040 44444444
M 00009050 55555555
M 00003100 77777777
T 3 80000001 0 0 0 00004010 00000000 0 0 11111111 ffffffff 00000000
T 0 00000001 0 0 1 00000500 cafef00d 0 0 00000000 00000500 cafef00d
T 1 00000000 0 0 0 00000500 00000000 0 0 cafef00d ffffffff 00000000
T 1 80000001 0 0 0 00000010 00000000 0 0 11111111 00002000 000010c7
T 1 80000001 0 0 1 00001020 12345678 0 0 00000000 00002004 000014c7
T 1 80000001 0 0 0 00001020 00000000 0 0 12345678 00005020 12345678
T 1 80000001 0 0 0 00002030 00000000 0 0 33333333 00002008 00001843
T 1 80000001 0 0 1 00002030 deadbeef 1 2 00000000 00006030 33333333
T 1 80000001 0 0 0 00003000 00000000 1 2 00000000 0000200c 00001c05
T 1 80000001 0 0 0 00004000 00000000 1 2 00000000 00002010 00001ce7
T 1 80000001 0 0 0 00005040 00000000 1 2 00000000 00008040 44444444
T 1 80000001 0 1 0 00005040 00000000 0 0 44444444 ffffffff 00000000
T 0 80000001 0 0 0 00005040 00000000 0 0 44444444 ffffffff 00000000
T 1 80000001 0 0 0 00006050 00000000 1 2 00000000 ffffffff 00000000
T 1 80000001 1 0 0 00006050 00000000 0 0 55555555 ffffffff 00000000
T 0 80000001 0 0 0 00007000 00000000 1 2 00000000 ffffffff 00000000
T 1 80000001 0 0 0 00403100 00000000 0 0 77777777 00001004 00000047
T 1 80000001 0 0 1 00403104 aabbccdd 0 0 00000000 00001004 000000c7
T 1 80000001 0 0 0 00800000 00000000 1 2 00000000 00001008 000004c7
T 1 80000001 0 0 0 00c00000 00000000 1 2 00000000 ffffffff 00000000
T 1 80000001 0 0 0 01000000 00000000 1 2 00000000 ffffffff 00000000
T 1 80000001 0 0 0 01400000 00000000 1 1 00000000 ffffffff 00000000
T 1 80000001 0 0 0 01800000 00000000 1 2 00000000 ffffffff 00000000
